/* rvCorePkg.sv */
package rvCorePkg;

    localparam int unsigned xlenW = 64;
    localparam logic [xlenW-1:0] resetVector = '0;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opOpImmW = 7'b0011011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpW    = 7'b0111011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB, aluNone
    } aluOpT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSelT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       srcAPc;
        logic       srcBImm;
        logic       wordOp;
        logic       writeRd;
        wbSelT      wbSel;
        immSelT     immSel;
        logic       memRead;
        logic       memWrite;
        logic [1:0] memSize;      // byte, half, word, double
        logic       loadUnsigned;
        logic       jump;
        logic       jumpReg;      // jalr
        logic       halt;
    } ctrlT;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [xlenW-1:0] adr;
        logic [xlenW-1:0] dat;
        logic [7:0]       sel;
    } wbReqT;

    typedef struct packed {
        logic             ack;
        logic [xlenW-1:0] dat;
    } wbRspT;

endpackage

/* rvDecoder.sv */
module rvDecoder (
    input  rvCorePkg::instT               inst,
    input  logic [rvCorePkg::xlenW-1:0]   rs1Val,
    input  logic [rvCorePkg::xlenW-1:0]   rs2Val,
    output rvCorePkg::ctrlT               ctrl,
    output logic                          takeBranch
);
    import rvCorePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altOk;
    logic       brCond;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    // bit 30 picks sub/sra, but addi has no sub form
    assign altOk  = inst.r.funct7[5]
                    && (funct3 == 3'b101 || opcode == opOp || opcode == opOpW);

    function automatic aluOpT aluFromF3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.aluOp  = aluNone;
        ctrl.wbSel  = wbAlu;
        ctrl.immSel = immI;
        case (opcode)
            opOp, opOpImm: begin
                ctrl.aluOp   = aluFromF3(funct3, altOk);
                ctrl.srcBImm = (opcode == opOpImm);
                ctrl.writeRd = 1'b1;
            end
            opOpW, opOpImmW: begin
                if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.aluOp   = aluFromF3(funct3, altOk);
                    ctrl.srcBImm = (opcode == opOpImmW);
                    ctrl.wordOp  = 1'b1;
                    ctrl.writeRd = 1'b1;
                end
            end
            opLui, opAuipc: begin
                ctrl.aluOp   = (opcode == opLui) ? aluPassB : aluAdd;
                ctrl.srcAPc  = 1'b1;    // ignored by passB
                ctrl.srcBImm = 1'b1;
                ctrl.immSel  = immU;
                ctrl.writeRd = 1'b1;
            end
            opJal: begin
                ctrl.jump    = 1'b1;
                ctrl.immSel  = immJ;
                ctrl.wbSel   = wbPcPlus4;
                ctrl.writeRd = 1'b1;
            end
            opJalr: begin
                ctrl.jumpReg = 1'b1;
                ctrl.aluOp   = aluAdd;  // target = rs1 + imm
                ctrl.srcBImm = 1'b1;
                ctrl.wbSel   = wbPcPlus4;
                ctrl.writeRd = 1'b1;
            end
            opBranch: begin
                ctrl.immSel = immB;
            end
            opLoad: begin
                if (funct3 != 3'b111) begin
                    ctrl.aluOp        = aluAdd;
                    ctrl.srcBImm      = 1'b1;
                    ctrl.memRead      = 1'b1;
                    ctrl.memSize      = funct3[1:0];
                    ctrl.loadUnsigned = funct3[2];
                    ctrl.wbSel        = wbMem;
                    ctrl.writeRd      = 1'b1;
                end
            end
            opStore: begin
                if (!funct3[2]) begin
                    ctrl.aluOp    = aluAdd;
                    ctrl.srcBImm  = 1'b1;
                    ctrl.immSel   = immS;
                    ctrl.memWrite = 1'b1;
                    ctrl.memSize  = funct3[1:0];
                end
            end
            opSystem: begin
                // only ebreak, the rest falls through as a no-op
                ctrl.halt = (inst.i.imm11_0 == 12'h001) && (funct3 == 3'b000);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst.b.funct3)
            3'b000:  brCond = (rs1Val == rs2Val);
            3'b001:  brCond = (rs1Val != rs2Val);
            3'b100:  brCond = ($signed(rs1Val) < $signed(rs2Val));
            3'b101:  brCond = ($signed(rs1Val) >= $signed(rs2Val));
            3'b110:  brCond = (rs1Val < rs2Val);
            3'b111:  brCond = (rs1Val >= rs2Val);
            default: brCond = 1'b0;
        endcase
    end

    assign takeBranch = (opcode == opBranch) && brCond;

    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("decoder requests load and store together");
    end

endmodule

/* rvImmGen.sv */
module rvImmGen (
    input  rvCorePkg::instT               inst,
    input  rvCorePkg::immSelT             immSel,
    output logic [rvCorePkg::xlenW-1:0]   imm
);
    import rvCorePkg::*;

    always_comb begin
        case (immSel)
            immS: imm = {{52{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            immB: imm = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                         inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            immU: imm = {{32{inst.u.imm31_12[19]}}, inst.u.imm31_12, 12'h000};
            immJ: imm = {{43{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                         inst.j.imm11, inst.j.imm10_1, 1'b0};
            default: imm = {{52{inst.i.imm11_0[11]}}, inst.i.imm11_0};
        endcase
    end

endmodule

/* rvAlu.sv */
module rvAlu (
    input  rvCorePkg::aluOpT              op,
    input  logic                          wordOp,
    input  logic [rvCorePkg::xlenW-1:0]   a,
    input  logic [rvCorePkg::xlenW-1:0]   b,
    output logic [rvCorePkg::xlenW-1:0]   result
);
    import rvCorePkg::*;

    logic [xlenW-1:0] aIn;
    logic [xlenW-1:0] full;
    logic [5:0]       shamt;

    always_comb begin
        aIn   = a;
        shamt = b[5:0];
        if (wordOp) begin
            // right shifts must see only the low word
            aIn   = (op == aluSra) ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
            shamt = {1'b0, b[4:0]};
        end
    end

    always_comb begin
        case (op)
            aluAdd:   full = aIn + b;
            aluSub:   full = aIn - b;
            aluSll:   full = aIn << shamt;
            aluSlt:   full = {63'b0, $signed(a) < $signed(b)};
            aluSltu:  full = {63'b0, a < b};
            aluXor:   full = aIn ^ b;
            aluSrl:   full = aIn >> shamt;
            aluSra:   full = $signed(aIn) >>> shamt;
            aluOr:    full = aIn | b;
            aluAnd:   full = aIn & b;
            aluPassB: full = b;
            default:  full = '0;
        endcase
    end

    assign result = wordOp ? {{32{full[31]}}, full[31:0]} : full;

endmodule

/* rvRegFile.sv */
module rvRegFile (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [4:0]                    rs1Addr,
    input  logic [4:0]                    rs2Addr,
    input  logic [4:0]                    rdAddr,
    input  logic                          rdWe,
    input  logic [rvCorePkg::xlenW-1:0]   rdData,
    output logic [rvCorePkg::xlenW-1:0]   rs1Val,
    output logic [rvCorePkg::xlenW-1:0]   rs2Val
);
    import rvCorePkg::*;

    logic [xlenW-1:0] regs [1:31];  // x0 is not stored

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Val = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
        rs1Addr == 5'd0 |-> rs1Val == '0);

endmodule

/* rvMemPort.sv */
module rvMemPort (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic [rvCorePkg::xlenW-1:0]   pc,
    input  rvCorePkg::ctrlT               ctrl,
    input  logic [rvCorePkg::xlenW-1:0]   aluResult,
    input  logic [rvCorePkg::xlenW-1:0]   storeData,
    output rvCorePkg::wbReqT              wbReq,
    input  rvCorePkg::wbRspT              wbRsp,
    output rvCorePkg::instT               inst,
    output logic [rvCorePkg::xlenW-1:0]   loadData,
    output logic                          retire,
    output logic                          halted
);
    import rvCorePkg::*;

    typedef enum logic [2:0] {stIdle, stFetch, stExecute, stMemory, stHalted} stateT;

    stateT            state;
    logic             memOp;
    logic             busy;
    logic [2:0]       off;
    logic [7:0]       sizeMask;
    logic [xlenW-1:0] laneData;

    assign memOp = ctrl.memRead || ctrl.memWrite;
    assign busy  = (state == stFetch) || (state == stMemory);
    assign off   = aluResult[2:0];

    always_comb begin
        case (ctrl.memSize)
            2'd0:    sizeMask = 8'h01;
            2'd1:    sizeMask = 8'h03;
            2'd2:    sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    // adr/dat/sel come from latched state, so they hold until ack
    always_comb begin
        wbReq     = '0;
        wbReq.cyc = busy;
        wbReq.stb = busy;
        wbReq.adr = {pc[xlenW-1:3], 3'b000};
        wbReq.sel = 8'hff;
        if (state == stMemory) begin
            wbReq.we  = ctrl.memWrite;
            wbReq.adr = {aluResult[xlenW-1:3], 3'b000};
            wbReq.dat = storeData << {off, 3'b000};
            wbReq.sel = sizeMask << off;
        end
    end

    assign laneData = wbRsp.dat >> {off, 3'b000};

    always_comb begin
        case (ctrl.memSize)
            2'd0: loadData = ctrl.loadUnsigned ? {56'b0, laneData[7:0]}
                                               : {{56{laneData[7]}}, laneData[7:0]};
            2'd1: loadData = ctrl.loadUnsigned ? {48'b0, laneData[15:0]}
                                               : {{48{laneData[15]}}, laneData[15:0]};
            2'd2: loadData = ctrl.loadUnsigned ? {32'b0, laneData[31:0]}
                                               : {{32{laneData[31]}}, laneData[31:0]};
            default: loadData = laneData;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            inst  <= '0;
        end else begin
            case (state)
                stIdle: state <= stFetch;
                stFetch: begin
                    if (wbRsp.ack) begin
                        inst  <= pc[2] ? wbRsp.dat[63:32] : wbRsp.dat[31:0];
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    if (ctrl.halt) begin
                        state <= stHalted;
                    end else if (memOp) begin
                        state <= stMemory;
                    end else begin
                        state <= stFetch;
                    end
                end
                stMemory: begin
                    if (wbRsp.ack) begin
                        state <= stIdle;    // one idle cycle between transfers
                    end
                end
                default: state <= stHalted;
            endcase
        end
    end

    assign retire = (state == stExecute && !memOp && !ctrl.halt)
                    || (state == stMemory && wbRsp.ack);
    assign halted = (state == stHalted);

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN)
        wbReq.stb |-> wbReq.cyc);

    adrHeld: assert property (@(posedge clk) disable iff (!arstN)
        wbReq.stb && !wbRsp.ack |=> $stable(wbReq.adr));

endmodule

/* rvCore.sv */
module rvCore (
    input  logic             clk,
    input  logic             arstN,
    output rvCorePkg::wbReqT wbReq,
    input  rvCorePkg::wbRspT wbRsp,
    output logic             halted
);
    import rvCorePkg::*;

    logic [xlenW-1:0] pc;
    logic [xlenW-1:0] imm;
    logic [xlenW-1:0] rs1Val;
    logic [xlenW-1:0] rs2Val;
    logic [xlenW-1:0] aluA;
    logic [xlenW-1:0] aluB;
    logic [xlenW-1:0] aluResult;
    logic [xlenW-1:0] loadData;
    logic [xlenW-1:0] rdData;
    instT             inst;
    ctrlT             ctrl;
    logic             takeBranch;
    logic             retire;

    rvDecoder iDecoder (
        .inst       (inst),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .ctrl       (ctrl),
        .takeBranch (takeBranch)
    );

    rvImmGen iImmGen (
        .inst   (inst),
        .immSel (ctrl.immSel),
        .imm    (imm)
    );

    assign aluA = ctrl.srcAPc ? pc : rs1Val;
    assign aluB = ctrl.srcBImm ? imm : rs2Val;

    rvAlu iAlu (
        .op     (ctrl.aluOp),
        .wordOp (ctrl.wordOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult)
    );

    always_comb begin
        case (ctrl.wbSel)
            wbMem:     rdData = loadData;
            wbPcPlus4: rdData = pc + 64'd4;     // link value
            default:   rdData = aluResult;
        endcase
    end

    rvRegFile iRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (inst.r.rs1),
        .rs2Addr (inst.r.rs2),
        .rdAddr  (inst.r.rd),
        .rdWe    (retire && ctrl.writeRd),
        .rdData  (rdData),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val)
    );

    rvMemPort iMemPort (
        .clk       (clk),
        .arstN     (arstN),
        .pc        (pc),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .storeData (rs2Val),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp),
        .inst      (inst),
        .loadData  (loadData),
        .retire    (retire),
        .halted    (halted)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetVector;
        end else if (retire) begin
            if (ctrl.jumpReg) begin
                pc <= {aluResult[xlenW-1:1], 1'b0};
            end else if (ctrl.jump || takeBranch) begin
                pc <= pc + imm;
            end else begin
                pc <= pc + 64'd4;
            end
        end
    end

    // once halted the bus stays quiet for good
    haltSticky: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted && !wbReq.cyc);

endmodule

/* rvCoreTb.sv */
module rvCoreTb;
    import rvCorePkg::*;

    localparam int memWords   = 256;            // 2 KB model
    localparam int dataBase   = 'h400;
    localparam int resultBase = 'h500;
    localparam int resultIdx  = resultBase / 8;
    localparam int storeBase  = 'h600;
    localparam int maxInsts   = 40;             // longest program
    localparam int worstCpi   = 8;              // 3 fetch + execute + 3 memory + idle
    localparam int cycleLimit = maxInsts * worstCpi + 80;

    logic  clk;
    logic  arstN;
    wbReqT wbReq;
    wbRspT wbRsp;
    logic  halted;

    logic [xlenW-1:0] mem [0:memWords-1];
    logic [31:0]      prog [$];
    logic [xlenW-1:0] expQ [$];
    wbReqT            storeQ [$];
    int               waitLeft;
    bit               fetchSeen;
    logic [xlenW-1:0] firstAdr;

    rvCore i_dut (
        .clk    (clk),
        .arstN  (arstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic endInFailure(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(input string what, input logic [xlenW-1:0] got,
                             input logic [xlenW-1:0] exp);
        if (got !== exp) begin
            endInFailure($sformatf("FAIL @%0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            endInFailure($sformatf("FAIL @%0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkBus(input string what, input wbReqT got, input wbReqT exp);
        logic [xlenW-1:0] mask;
        for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{exp.sel[b]}};  // unselected lanes are don't care
        end
        if (got.cyc !== exp.cyc || got.stb !== exp.stb || got.we !== exp.we
            || got.adr !== exp.adr || got.sel !== exp.sel
            || (got.dat & mask) !== (exp.dat & mask)) begin
            endInFailure($sformatf(
                "FAIL @%0t: %s we=%b adr=%h sel=%h dat=%h, expected we=%b adr=%h sel=%h dat=%h",
                $time, what, got.we, got.adr, got.sel, got.dat & mask,
                exp.we, exp.adr, exp.sel, exp.dat & mask));
        end
    endtask

    // Wishbone slave, one call per cycle
    task automatic serviceBus();
        logic [7:0] idx;
        wbRsp.ack = 1'b0;
        if (!arstN) begin
            waitLeft  = -1;
            fetchSeen = 1'b0;
            storeQ.delete();
        end else begin
            if (halted && wbReq.cyc) begin
                endInFailure("a bus cycle started after ebreak halted the core");
            end
            if (wbReq.cyc && wbReq.stb) begin
                if (!fetchSeen) begin
                    firstAdr  = wbReq.adr;
                    fetchSeen = 1'b1;
                end
                if (waitLeft < 0) begin
                    waitLeft = int'($urandom_range(2, 0));
                end
                if (waitLeft == 0) begin
                    if (wbReq.adr[63:11] != '0) begin
                        endInFailure($sformatf("bus access outside the memory at %h", wbReq.adr));
                    end
                    idx = wbReq.adr[10:3];
                    if (wbReq.we) begin
                        for (int b = 0; b < 8; b++) begin
                            if (wbReq.sel[b]) mem[idx][8*b +: 8] = wbReq.dat[8*b +: 8];
                        end
                        storeQ.push_back(wbReq);
                    end else begin
                        wbRsp.dat = mem[idx];
                    end
                    wbRsp.ack = 1'b1;
                    waitLeft  = -1;
                end else begin
                    waitLeft--;
                end
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        serviceBus();
    endtask

    function automatic logic [xlenW-1:0] fillOf(input int idx);
        return {24'h5A5A5A, idx[7:0], 24'hA5A5A5, ~idx[7:0]};
    endfunction

    function automatic logic [31:0] rFormat(input int f7, input int rs2, input int rs1,
                                            input int f3, input int rd, input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] iFormat(input int imm, input int rs1, input int f3,
                                            input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sFormat(input int imm, input int rs2, input int rs1,
                                            input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bFormat(input int imm, input int rs2, input int rs1,
                                            input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uFormat(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jFormat(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    function automatic int here();
        return prog.size() * 4;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // sd of rs into the next result slot
    task automatic storeResult(input int rs, input logic [xlenW-1:0] expected);
        emit(sFormat(resultBase + 8 * expQ.size(), rs, 0, 3));
        expQ.push_back(expected);
    endtask

    function automatic logic [31:0] aluInst(input int kind, input int rd, input int rs1,
                                            input int rs2);
        case (kind)
            0:       return rFormat(0, rs2, rs1, 0, rd, opOp);     // add
            1:       return rFormat(32, rs2, rs1, 0, rd, opOp);    // sub
            2:       return rFormat(0, rs2, rs1, 1, rd, opOp);     // sll
            3:       return rFormat(0, rs2, rs1, 2, rd, opOp);     // slt
            4:       return rFormat(0, rs2, rs1, 3, rd, opOp);     // sltu
            5:       return rFormat(0, rs2, rs1, 4, rd, opOp);     // xor
            6:       return rFormat(0, rs2, rs1, 5, rd, opOp);     // srl
            7:       return rFormat(32, rs2, rs1, 5, rd, opOp);    // sra
            8:       return rFormat(0, rs2, rs1, 6, rd, opOp);     // or
            9:       return rFormat(0, rs2, rs1, 7, rd, opOp);     // and
            10:      return rFormat(0, rs2, rs1, 0, rd, opOpW);    // addw
            11:      return rFormat(32, rs2, rs1, 0, rd, opOpW);   // subw
            12:      return rFormat(0, rs2, rs1, 1, rd, opOpW);    // sllw
            13:      return rFormat(0, rs2, rs1, 5, rd, opOpW);    // srlw
            default: return rFormat(32, rs2, rs1, 5, rd, opOpW);   // sraw
        endcase
    endfunction

    function automatic logic [xlenW-1:0] aluModel(input int kind, input logic [xlenW-1:0] a,
                                                  input logic [xlenW-1:0] b);
        logic [31:0] w;
        w = '0;
        case (kind)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[5:0];
            3:       return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            4:       return (a < b) ? 64'd1 : 64'd0;
            5:       return a ^ b;
            6:       return a >> b[5:0];
            7:       return $signed(a) >>> b[5:0];
            8:       return a | b;
            9:       return a & b;
            10:      w = a[31:0] + b[31:0];
            11:      w = a[31:0] - b[31:0];
            12:      w = a[31:0] << b[4:0];
            13:      w = a[31:0] >> b[4:0];
            default: w = $signed(a[31:0]) >>> b[4:0];
        endcase
        return {{32{w[31]}}, w};     // W forms sign-extend bit 31
    endfunction

    function automatic logic [xlenW-1:0] loadModel(input logic [xlenW-1:0] d, input int size,
                                                   input int uns, input int off);
        logic [xlenW-1:0] v;
        logic [xlenW-1:0] keep;
        int               bits;
        v    = d >> (8 * off);
        bits = 8 << size;
        if (bits == 64) return v;
        keep = (64'd1 << bits) - 64'd1;
        v    = v & keep;
        if (uns == 0 && v[bits-1]) v = v | ~keep;
        return v;
    endfunction

    task automatic startProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = fillOf(i);
        end
        prog.delete();
        expQ.delete();
    endtask

    task automatic resetCore();
        tick();
        arstN = 1'b0;
        repeat (2) begin
            tick();
            checkBit("cyc during reset", wbReq.cyc, 1'b0);
            checkBit("stb during reset", wbReq.stb, 1'b0);
            checkBit("halted during reset", halted, 1'b0);
        end
        arstN = 1'b1;
        checkBit("cyc after reset", wbReq.cyc, 1'b0);
        checkBit("halted after reset", halted, 1'b0);
    endtask

    task automatic runProgram();
        int cycles;
        cycles = 0;
        while (!halted) begin
            if (cycles >= cycleLimit) begin
                endInFailure($sformatf("timeout, the core did not halt within %0d cycles",
                                       cycleLimit));
            end
            tick();
            cycles++;
        end
        repeat (4) tick();    // bus must stay quiet
        checkBit("halted stays high", halted, 1'b1);
        checkBit("cyc after halt", wbReq.cyc, 1'b0);
        checkWord("first fetch address", firstAdr, resetVector);
    endtask

    task automatic loadAndRun();
        if (prog.size() > maxInsts) begin
            endInFailure($sformatf("a test program has %0d instructions, more than %0d",
                                   prog.size(), maxInsts));
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[i / 2][32 * (i % 2) +: 32] = prog[i];
        end
        resetCore();
        runProgram();
    endtask

    task automatic checkResults(input string tag);
        for (int k = 0; k < expQ.size(); k++) begin
            checkWord($sformatf("%s result %0d", tag, k), mem[resultIdx + k], expQ[k]);
        end
    endtask

    task automatic testUpper();
        int p;
        startProgram();
        emit(uFormat('h12345, 1, opLui));
        emit(uFormat('h80001, 2, opLui));
        p = here();
        emit(uFormat('h00001, 3, opAuipc));
        emit(uFormat('hFFFFF, 4, opAuipc));
        storeResult(1, 64'h0000_0000_1234_5000);
        storeResult(2, 64'hFFFF_FFFF_8000_1000);
        storeResult(3, 64'(p) + 64'h1000);
        storeResult(4, 64'(p + 4) - 64'h1000);
        emit(iFormat(1, 0, 0, 0, opSystem));    // ebreak
        storeResult(1, fillOf(resultIdx + expQ.size()));   // never fetched
        loadAndRun();
        checkResults("upper");
    endtask

    task automatic testAlu(input logic [xlenW-1:0] a, input logic [xlenW-1:0] b);
        startProgram();
        mem[dataBase / 8]     = a;
        mem[dataBase / 8 + 1] = b;
        emit(iFormat(dataBase, 0, 3, 1, opLoad));
        emit(iFormat(dataBase + 8, 0, 3, 2, opLoad));
        for (int k = 0; k < 15; k++) begin
            emit(aluInst(k, 3, 1, 2));
            storeResult(3, aluModel(k, a, b));
        end
        emit(iFormat(-5, 1, 0, 4, opOpImm));
        storeResult(4, a - 64'd5);
        emit(iFormat(3, 1, 0, 5, opOpImmW));
        storeResult(5, aluModel(10, a, 64'd3));     // addiw follows the addw rule
        emit(iFormat(1, 0, 0, 0, opSystem));
        loadAndRun();
        checkResults("alu");
    endtask

    task automatic testStores(input logic [xlenW-1:0] v);
        wbReqT busQ [$];
        wbReqT exp;
        startProgram();
        mem[dataBase / 8] = v;
        emit(iFormat(dataBase, 0, 3, 1, opLoad));
        for (int size = 0; size < 4; size++) begin
            for (int off = 0; off < 8; off += 1 << size) begin
                emit(sFormat(storeBase + 8 * size + off, 1, 0, size));
                exp     = '0;
                exp.cyc = 1'b1;
                exp.stb = 1'b1;
                exp.we  = 1'b1;
                exp.adr = 64'(storeBase + 8 * size);
                exp.sel = 8'(((1 << (1 << size)) - 1) << off);
                exp.dat = v << (8 * off);
                busQ.push_back(exp);
            end
        end
        emit(iFormat(1, 0, 0, 0, opSystem));
        loadAndRun();
        checkWord("store count", 64'(storeQ.size()), 64'(busQ.size()));
        for (int k = 0; k < busQ.size(); k++) begin
            checkBus($sformatf("store %0d", k), storeQ[k], busQ[k]);
        end
        checkWord("bytes stored", mem[storeBase / 8], {8{v[7:0]}});
        checkWord("halves stored", mem[storeBase / 8 + 1], {4{v[15:0]}});
        checkWord("words stored", mem[storeBase / 8 + 2], {2{v[31:0]}});
        checkWord("double stored", mem[storeBase / 8 + 3], v);
    endtask

    task automatic testLoads(input logic [xlenW-1:0] d, input int minSize, input int maxSize);
        startProgram();
        mem[dataBase / 8] = d;
        for (int size = minSize; size <= maxSize; size++) begin
            for (int uns = 0; uns < 2; uns++) begin
                if (size == 3 && uns == 1) continue;   // no ldu
                for (int off = 0; off < 8; off += 1 << size) begin
                    emit(iFormat(dataBase + off, 0, size + 4 * uns, 5, opLoad));
                    storeResult(5, loadModel(d, size, uns, off));
                end
            end
        end
        emit(iFormat(1, 0, 0, 0, opSystem));
        loadAndRun();
        checkResults("load");
    endtask

    task automatic branchStep(input int f3, input int rs1, input int rs2, input bit taken);
        emit(bFormat(8, rs2, rs1, f3));
        storeResult(10, taken ? fillOf(resultIdx + expQ.size()) : 64'd1);
    endtask

    task automatic testBranches();
        int pcJal;
        int pcJalr;
        int target;
        startProgram();
        mem[dataBase / 8]     = 64'hFFFF_FFFF_FFFF_FFFD;   // -3
        mem[dataBase / 8 + 1] = 64'd5;
        emit(iFormat(dataBase, 0, 3, 1, opLoad));
        emit(iFormat(dataBase + 8, 0, 3, 2, opLoad));
        emit(iFormat(1, 0, 0, 10, opOpImm));     // x10 = 1 overwrites a marker
        branchStep(0, 1, 2, 1'b0);   // beq
        branchStep(0, 1, 1, 1'b1);
        branchStep(1, 1, 2, 1'b1);   // bne
        branchStep(4, 1, 2, 1'b1);   // blt, signed -3 < 5
        branchStep(5, 1, 2, 1'b0);   // bge
        branchStep(6, 1, 2, 1'b0);   // bltu, -3 is huge unsigned
        branchStep(7, 1, 2, 1'b1);   // bgeu
        pcJal = here();
        emit(jFormat(8, 11));
        storeResult(10, fillOf(resultIdx + expQ.size()));
        target = here() + 12;
        emit(iFormat(target + 1, 0, 0, 13, opOpImm));  // odd target, bit 0 dropped
        pcJalr = here();
        emit(iFormat(0, 13, 0, 12, opJalr));
        storeResult(10, fillOf(resultIdx + expQ.size()));
        storeResult(11, 64'(pcJal + 4));
        storeResult(12, 64'(pcJalr + 4));
        emit(iFormat(1, 0, 0, 0, opSystem));
        loadAndRun();
        checkResults("branch");
    endtask

    initial begin
        void'($urandom(82));
        arstN = 1'b0;
        wbRsp = '0;
        testUpper();
        testAlu(64'h0000_0000_7FFF_FFFF, 64'd1);
        testAlu(64'hFFFF_FFFF_FFFF_FFF8, 64'd3);
        repeat (2) testAlu({$urandom, $urandom}, {$urandom, $urandom});
        testStores(64'hF0E1_D2C3_B4A5_9687);
        testLoads(64'h70F1_8F02_C3E4_5A96, 0, 0);
        testLoads(64'h70F1_8F02_C3E4_5A96, 1, 3);
        testBranches();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* rvCore.f */
rvCorePkg.sv
rvDecoder.sv
rvImmGen.sv
rvAlu.sv
rvRegFile.sv
rvMemPort.sv
rvCore.sv
rvCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f

# the simulator exits non-zero on failure, the grep below decides
out=$(./obj_dir/VrvCoreTb 2>&1) || true
echo "$out"
echo "$out" | grep -qx "TEST PASS"
